//--- Makefile
SIM       := verilator
TOP       := xbar_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- src/carry_chain_adder.sv
// ------------------
// 8-bit carry-lookahead adder
// ------------------
`timescale 1ns/10ps
`default_nettype none

module carry_chain_adder (
  input  wire [pkt_pkg::DATA_W-1:0]    a,
  input  wire [pkt_pkg::DATA_W-1:0]    b,
  output logic [pkt_pkg::DATA_W-1:0]   sum
);

  logic [pkt_pkg::DATA_W-1:0] p;
  logic [pkt_pkg::DATA_W-1:0] g;
  logic [pkt_pkg::DATA_W-1:0] c;

  assign p = a ^ b;
  assign g = a & b;

  // c[i] = g[i-1] | p[i-1]g[i-2] | ... flattened per bit, no carry in
  always_comb begin
    logic pp;
    c[0] = 1'b0;
    for (int i = 1; i < pkt_pkg::DATA_W; i++) begin
      c[i] = 1'b0;
      pp   = 1'b1;
      for (int j = i - 1; j >= 0; j--) begin
        c[i] = c[i] | (g[j] & pp);
        pp   = pp & p[j];
      end
    end
  end

  // top carry dropped, wraps mod 256
  assign sum = p ^ c;

endmodule

`default_nettype wire

//--- src/dst_fifo.sv
// ------------------
// first-word-fall-through FIFO for one destination
// ------------------
`timescale 1ns/10ps
`default_nettype none

module dst_fifo #(
  parameter int DEPTH = 4
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          push,
  input  wire pkt_pkg::opcode_t        push_op,
  input  wire [pkt_pkg::DATA_W-1:0]    push_data,
  input  wire [xbar_pkg::IDX_W-1:0]    push_src,
  output logic                         full,
  output logic                         empty,
  input  wire                          pop,
  output pkt_pkg::opcode_t             head_op,
  output logic [pkt_pkg::DATA_W-1:0]   head_data,
  output logic [xbar_pkg::IDX_W-1:0]   head_src
);

  localparam int AW = $clog2(DEPTH);

  pkt_pkg::opcode_t             mem_op [DEPTH];
  logic [pkt_pkg::DATA_W-1:0]   mem_data [DEPTH];
  logic [xbar_pkg::IDX_W-1:0]   mem_src [DEPTH];
  logic [AW-1:0]                wr_ptr;
  logic [AW-1:0]                rd_ptr;
  logic [AW:0]                  count;
  logic                         wr_en;
  logic                         rd_en;

  assign full  = (count == (AW + 1)'(DEPTH));
  assign empty = (count == '0);
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own, DEPTH is a power of two
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en) count <= count + 1'b1;
      else if (rd_en && !wr_en) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_op[wr_ptr]   <= push_op;
      mem_data[wr_ptr] <= push_data;
      mem_src[wr_ptr]  <= push_src;
    end
  end

  assign head_op   = mem_op[rd_ptr];
  assign head_data = mem_data[rd_ptr];
  assign head_src  = mem_src[rd_ptr];

endmodule

`default_nettype wire

//--- src/dst_port.sv
// ------------------
// destination port: executes opcode,
// four-phase result handshake
// ------------------
`timescale 1ns/10ps
`default_nettype none

module dst_port (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          empty,
  input  wire pkt_pkg::opcode_t        head_op,
  input  wire [pkt_pkg::DATA_W-1:0]    head_data,
  input  wire [xbar_pkg::IDX_W-1:0]    head_src,
  output logic                         pop,
  output logic                         out_req,
  output logic [pkt_pkg::DATA_W-1:0]   out_data,
  output logic [xbar_pkg::IDX_W-1:0]   out_src,
  input  wire                          out_ack
);

  pkt_pkg::dst_state_t          state;
  logic [pkt_pkg::DATA_W-1:0]   acc;
  logic [pkt_pkg::DATA_W-1:0]   sum;
  logic [pkt_pkg::DATA_W-1:0]   result;

  carry_chain_adder adder_i (
    .a   (acc),
    .b   (head_data),
    .sum (sum)
  );

  assign result = (head_op == pkt_pkg::OP_ADD) ? sum : head_data;

  // take the head as soon as the output side is free
  assign pop = (state == pkt_pkg::D_IDLE) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= pkt_pkg::D_IDLE;
      out_req <= 1'b0;
      acc     <= '0;
    end else begin
      case (state)
        pkt_pkg::D_IDLE: begin
          if (!empty) begin
            out_req <= 1'b1;
            state   <= pkt_pkg::D_REQ_HI;
            if (head_op == pkt_pkg::OP_ADD) acc <= sum;
          end
        end
        pkt_pkg::D_REQ_HI: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= pkt_pkg::D_WAIT_ACK_LO;
          end
        end
        pkt_pkg::D_WAIT_ACK_LO: begin
          if (!out_ack) state <= pkt_pkg::D_IDLE;
        end
        default: state <= pkt_pkg::D_IDLE;
      endcase
    end
  end

  // result and its source tag, held through the handshake
  always_ff @(posedge clk) begin
    if (pop) begin
      out_data <= result;
      out_src  <= head_src;
    end
  end

endmodule

`default_nettype wire

//--- src/pkt_pkg.sv
// ------------------
// packet format: opcodes, payload width,
// destination-port FSM states
// ------------------
`default_nettype none

package pkt_pkg;

  // payload width in bits
  parameter int DATA_W = 8;

  typedef enum logic {
    OP_WRITE,
    OP_ADD
  } opcode_t;

  // result handshake toward the outside
  typedef enum logic [1:0] {
    D_IDLE,
    D_REQ_HI,
    D_WAIT_ACK_LO
  } dst_state_t;

endpackage

`default_nettype wire

//--- src/src_port.sv
// ------------------
// source port: four-phase input side and
// switch request held until granted
// ------------------
`timescale 1ns/10ps
`default_nettype none

module src_port (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          in_req,
  input  wire [xbar_pkg::IDX_W-1:0]    in_dest,
  input  wire pkt_pkg::opcode_t        in_op,
  input  wire [pkt_pkg::DATA_W-1:0]    in_data,
  output logic                         in_ack,
  output logic                         sw_req,
  output logic [xbar_pkg::IDX_W-1:0]   sw_dest,
  output pkt_pkg::opcode_t             sw_op,
  output logic [pkt_pkg::DATA_W-1:0]   sw_data,
  input  wire                          gnt
);

  xbar_pkg::src_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= xbar_pkg::S_IDLE;
      sw_req <= 1'b0;
      in_ack <= 1'b0;
    end else begin
      case (state)
        xbar_pkg::S_IDLE: begin
          if (in_req) begin
            sw_req <= 1'b1;
            state  <= xbar_pkg::S_WAIT_GNT;
          end
        end
        xbar_pkg::S_WAIT_GNT: begin
          // packet is in the switch once gnt pulses
          if (gnt) begin
            sw_req <= 1'b0;
            in_ack <= 1'b1;
            state  <= xbar_pkg::S_ACK_HI;
          end
        end
        xbar_pkg::S_ACK_HI, xbar_pkg::S_WAIT_REQ_LO: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= xbar_pkg::S_IDLE;
          end else begin
            state <= xbar_pkg::S_WAIT_REQ_LO;
          end
        end
        default: state <= xbar_pkg::S_IDLE;
      endcase
    end
  end

  // fields are stable while in_req is high
  always_ff @(posedge clk) begin
    if (state == xbar_pkg::S_IDLE && in_req) begin
      sw_dest <= in_dest;
      sw_op   <= in_op;
      sw_data <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- src/xbar_pkg.sv
// ------------------
// crossbar structure constants and source-port FSM states
// ------------------
`default_nettype none

package xbar_pkg;

  // default port count for the top level
  parameter int NUM_PORTS = 4;

  // width of a source or destination index
  parameter int IDX_W = 2;

  // source port handshake states
  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_GNT,
    S_ACK_HI,
    S_WAIT_REQ_LO
  } src_state_t;

endpackage

`default_nettype wire

//--- src/xbar_switch.sv
// ------------------
// fixed-priority crossbar arbiter, registered grants
// and per-destination word steering
// ------------------
`timescale 1ns/10ps
`default_nettype none

module xbar_switch #(
  parameter int N = xbar_pkg::NUM_PORTS
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire [N-1:0]                  sw_req,
  input  wire [xbar_pkg::IDX_W-1:0]    sw_dest [N],
  input  wire pkt_pkg::opcode_t        sw_op [N],
  input  wire [pkt_pkg::DATA_W-1:0]    sw_data [N],
  output logic [N-1:0]                 gnt,
  input  wire [N-1:0]                  full,
  output logic [N-1:0]                 push,
  output pkt_pkg::opcode_t             push_op [N],
  output logic [pkt_pkg::DATA_W-1:0]   push_data [N],
  output logic [xbar_pkg::IDX_W-1:0]   push_src [N]
);

  logic [N-1:0]                gnt_next;
  logic [N-1:0]                push_next;
  logic [xbar_pkg::IDX_W-1:0]  sel_src [N];
  logic [xbar_pkg::IDX_W-1:0]  dest;

  // lowest source index wins each destination
  always_comb begin
    gnt_next  = '0;
    push_next = '0;
    dest      = '0;
    for (int d = 0; d < N; d++) begin
      sel_src[d] = '0;
    end
    for (int s = 0; s < N; s++) begin
      dest = sw_dest[s];
      // a source just granted still shows its request this cycle
      if (sw_req[s] && !gnt[s] && !full[dest] && !push[dest] &&
          !push_next[dest]) begin
        gnt_next[s]     = 1'b1;
        push_next[dest] = 1'b1;
        sel_src[dest]   = (xbar_pkg::IDX_W)'(s);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gnt  <= '0;
      push <= '0;
    end else begin
      gnt  <= gnt_next;
      push <= push_next;
    end
  end

  // steered words, only loaded when a push goes out
  always_ff @(posedge clk) begin
    for (int d = 0; d < N; d++) begin
      if (push_next[d]) begin
        push_op[d]   <= sw_op[sel_src[d]];
        push_data[d] <= sw_data[sel_src[d]];
        push_src[d]  <= sel_src[d];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/xbar_top.sv
// ------------------
// crossbar top: sources, switch, FIFOs, destinations
// ------------------
`timescale 1ns/10ps
`default_nettype none

module xbar_top #(
  parameter int N     = xbar_pkg::NUM_PORTS,
  parameter int DEPTH = 4
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire [N-1:0]                  in_req,
  input  wire [xbar_pkg::IDX_W-1:0]    in_dest [N],
  input  wire pkt_pkg::opcode_t        in_op [N],
  input  wire [pkt_pkg::DATA_W-1:0]    in_data [N],
  output logic [N-1:0]                 in_ack,
  output logic [N-1:0]                 out_req,
  output logic [pkt_pkg::DATA_W-1:0]   out_data [N],
  output logic [xbar_pkg::IDX_W-1:0]   out_src [N],
  input  wire [N-1:0]                  out_ack
);

  // source side
  logic [N-1:0]                sw_req;
  logic [xbar_pkg::IDX_W-1:0]  sw_dest [N];
  pkt_pkg::opcode_t            sw_op [N];
  logic [pkt_pkg::DATA_W-1:0]  sw_data [N];
  logic [N-1:0]                gnt;

  // switch to FIFOs
  logic [N-1:0]                full;
  logic [N-1:0]                push;
  pkt_pkg::opcode_t            push_op [N];
  logic [pkt_pkg::DATA_W-1:0]  push_data [N];
  logic [xbar_pkg::IDX_W-1:0]  push_src [N];

  // FIFOs to destinations
  logic [N-1:0]                empty;
  logic [N-1:0]                pop;
  pkt_pkg::opcode_t            head_op [N];
  logic [pkt_pkg::DATA_W-1:0]  head_data [N];
  logic [xbar_pkg::IDX_W-1:0]  head_src [N];

  for (genvar s = 0; s < N; s++) begin : g_src
    src_port src_i (
      .clk     (clk),
      .rst     (rst),
      .in_req  (in_req[s]),
      .in_dest (in_dest[s]),
      .in_op   (in_op[s]),
      .in_data (in_data[s]),
      .in_ack  (in_ack[s]),
      .sw_req  (sw_req[s]),
      .sw_dest (sw_dest[s]),
      .sw_op   (sw_op[s]),
      .sw_data (sw_data[s]),
      .gnt     (gnt[s])
    );
  end

  xbar_switch #(.N(N)) switch_i (
    .clk       (clk),
    .rst       (rst),
    .sw_req    (sw_req),
    .sw_dest   (sw_dest),
    .sw_op     (sw_op),
    .sw_data   (sw_data),
    .gnt       (gnt),
    .full      (full),
    .push      (push),
    .push_op   (push_op),
    .push_data (push_data),
    .push_src  (push_src)
  );

  for (genvar d = 0; d < N; d++) begin : g_dst
    dst_fifo #(.DEPTH(DEPTH)) fifo_i (
      .clk       (clk),
      .rst       (rst),
      .push      (push[d]),
      .push_op   (push_op[d]),
      .push_data (push_data[d]),
      .push_src  (push_src[d]),
      .full      (full[d]),
      .empty     (empty[d]),
      .pop       (pop[d]),
      .head_op   (head_op[d]),
      .head_data (head_data[d]),
      .head_src  (head_src[d])
    );

    dst_port dst_i (
      .clk       (clk),
      .rst       (rst),
      .empty     (empty[d]),
      .head_op   (head_op[d]),
      .head_data (head_data[d]),
      .head_src  (head_src[d]),
      .pop       (pop[d]),
      .out_req   (out_req[d]),
      .out_data  (out_data[d]),
      .out_src   (out_src[d]),
      .out_ack   (out_ack[d])
    );
  end

endmodule

`default_nettype wire

//--- verification/xbar_input.txt
// columns: source, destination, opcode (0 write, 1 add), payload, all hex
// a line of ff ends the list; each source sends its lines in order
0 2 1 ff
1 2 1 01
2 2 0 5a
3 2 1 80
0 0 1 01
0 0 1 ff
1 1 0 c3
1 3 1 7f
2 3 1 81
3 3 0 11
0 3 1 0f
1 0 0 22
2 1 1 f0
3 1 1 1f
0 2 0 aa
3 2 1 7e
ff ff ff ff

//--- verification/xbar_tb.sv
// --------------------
// crossbar testbench with file-driven sources, random output
// back-pressure and a scoreboard per source/destination pair
// --------------------
`timescale 1ns/10ps
`default_nettype none

module xbar_tb;

  localparam int N          = xbar_pkg::NUM_PORTS;
  localparam int DEPTH      = 4;
  localparam int PKT_W      = xbar_pkg::IDX_W + 1 + pkt_pkg::DATA_W;
  localparam int MAX_WORDS  = 128;
  localparam int WAIT_LIMIT = 2000;
  localparam int RUN_LIMIT  = 20000;

  logic                               clk;
  logic                               rst;
  wire  [N-1:0]                       in_req;
  wire  [xbar_pkg::IDX_W-1:0]         in_dest [N];
  wire  pkt_pkg::opcode_t             in_op [N];
  wire  [pkt_pkg::DATA_W-1:0]         in_data [N];
  logic [N-1:0]                       in_ack;
  logic [N-1:0]                       out_req;
  logic [pkt_pkg::DATA_W-1:0]         out_data [N];
  logic [xbar_pkg::IDX_W-1:0]         out_src [N];
  wire  [N-1:0]                       out_ack;

  // four words per packet in source, destination, opcode, payload order
  logic [7:0]                   stim_words [MAX_WORDS];
  // {dest, op, payload} per source in file order
  logic [PKT_W-1:0]             stim_q [N][$];
  // {op, payload} per pair at index s*N+d
  logic [pkt_pkg::DATA_W:0]     exp_q [N*N][$];
  logic [pkt_pkg::DATA_W-1:0]   model_acc [N];
  int                           exp_per_dst [N];
  int                           sent_count [N];
  int                           rcv_count [N];
  int                           total;
  logic                         reset_done;
  logic [31:0]                  lfsr_state;

  xbar_top #(.N(N), .DEPTH(DEPTH)) dut_i (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_dest  (in_dest),
    .in_op    (in_op),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_src  (out_src),
    .out_ack  (out_ack)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] v);
    return v[0] ? ((v >> 1) ^ 32'h8020_0003) : (v >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic draw_bits(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      value      = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_stimulus();
    int i;
    int s;
    int d;
    $readmemh("verification/xbar_input.txt", stim_words);
    total = 0;
    for (int k = 0; k < N; k++) begin
      exp_per_dst[k] = 0;
    end
    i = 0;
    while (i + 3 < MAX_WORDS && stim_words[i] !== 8'hff) begin
      s = int'(stim_words[i]);
      d = int'(stim_words[i + 1]);
      assert (s < N && d < N && stim_words[i + 2] < 8'd2)
        else stop_on_error($sformatf("packet %0d in the stimulus file is malformed", i / 4));
      stim_q[s].push_back({stim_words[i + 1][xbar_pkg::IDX_W-1:0],
                           stim_words[i + 2][0], stim_words[i + 3]});
      exp_q[s * N + d].push_back({stim_words[i + 2][0], stim_words[i + 3]});
      exp_per_dst[d]++;
      total++;
      i += 4;
    end
    assert (total > 0) else stop_on_error("the stimulus file holds no packets");
  endtask

  task automatic wait_reset_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!reset_done) begin
      cycles++;
      assert (cycles < WAIT_LIMIT) else stop_on_error("reset was never released");
      @(negedge clk);
    end
  endtask

  task automatic wait_in_ack(input int s, input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (in_ack[s] != level) begin
      cycles++;
      assert (cycles < WAIT_LIMIT)
        else stop_on_error($sformatf("in_ack[%0d] never went to %b", s, level));
      @(negedge clk);
    end
  endtask

  task automatic wait_out_req(input int d, input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (out_req[d] != level) begin
      cycles++;
      assert (cycles < WAIT_LIMIT)
        else stop_on_error($sformatf("out_req[%0d] never went to %b", d, level));
      @(negedge clk);
    end
  endtask

  task automatic check_outputs_low();
    assert (in_ack == '0) else stop_on_error($sformatf(
      "MISMATCH at %0t: in_ack = %b, expected %b", $time, in_ack, {N{1'b0}}));
    assert (out_req == '0) else stop_on_error($sformatf(
      "MISMATCH at %0t: out_req = %b, expected %b", $time, out_req, {N{1'b0}}));
  endtask

  // oldest open packet from the tagged source decides the expected value
  task automatic check_result(input int d);
    int                          s;
    logic [pkt_pkg::DATA_W:0]    entry;
    logic [pkt_pkg::DATA_W-1:0]  want;
    s = int'(out_src[d]);
    assert (exp_q[s * N + d].size() > 0) else stop_on_error($sformatf(
      "destination %0d delivered a result from source %0d that was not expected", d, s));
    entry = exp_q[s * N + d].pop_front();
    if (pkt_pkg::opcode_t'(entry[pkt_pkg::DATA_W]) == pkt_pkg::OP_ADD) begin
      want         = model_acc[d] + entry[pkt_pkg::DATA_W-1:0];
      model_acc[d] = want;
    end else begin
      want = entry[pkt_pkg::DATA_W-1:0];
    end
    assert (out_data[d] == want) else stop_on_error($sformatf(
      "MISMATCH at %0t: out_data[%0d] = %02h, expected %02h", $time, d, out_data[d], want));
  endtask

  function automatic bit all_done();
    int n_sent;
    int n_rcv;
    n_sent = 0;
    n_rcv  = 0;
    for (int k = 0; k < N; k++) begin
      n_sent += sent_count[k];
      n_rcv  += rcv_count[k];
    end
    return (n_sent == total) && (n_rcv == total);
  endfunction

  for (genvar s = 0; s < N; s++) begin : g_drv
    logic                        drv_req;
    logic [xbar_pkg::IDX_W-1:0]  drv_dest;
    pkt_pkg::opcode_t            drv_op;
    logic [pkt_pkg::DATA_W-1:0]  drv_data;

    assign in_req[s]  = drv_req;
    assign in_dest[s] = drv_dest;
    assign in_op[s]   = drv_op;
    assign in_data[s] = drv_data;

    initial begin : send_packets
      logic [PKT_W-1:0] pkt;
      drv_req  = 1'b0;
      drv_dest = '0;
      drv_op   = pkt_pkg::OP_WRITE;
      drv_data = '0;
      wait_reset_done();
      while (stim_q[s].size() > 0) begin
        pkt = stim_q[s].pop_front();
        @(posedge clk);
        #1;
        drv_dest = pkt[PKT_W-1 -: xbar_pkg::IDX_W];
        drv_op   = pkt_pkg::opcode_t'(pkt[pkt_pkg::DATA_W]);
        drv_data = pkt[pkt_pkg::DATA_W-1:0];
        drv_req  = 1'b1;
        wait_in_ack(s, 1'b1);
        @(posedge clk);
        #1;
        drv_req = 1'b0;
        wait_in_ack(s, 1'b0);
        sent_count[s]++;
      end
    end
  end

  for (genvar d = 0; d < N; d++) begin : g_rsp
    logic rsp_ack;

    assign out_ack[d] = rsp_ack;

    initial begin : accept_results
      int delay;
      rsp_ack = 1'b0;
      wait_reset_done();
      while (rcv_count[d] < exp_per_dst[d]) begin
        wait_out_req(d, 1'b1);
        check_result(d);
        // 0 to 7 cycles of back-pressure
        draw_bits(3, delay);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        rsp_ack = 1'b1;
        wait_out_req(d, 1'b0);
        @(posedge clk);
        #1;
        rsp_ack = 1'b0;
        rcv_count[d]++;
      end
    end
  end

  initial begin : main_sequence
    int cycles;
    clk        = 1'b0;
    rst        = 1'b1;
    reset_done = 1'b0;
    lfsr_state = 32'hc792_32d1;
    for (int k = 0; k < N; k++) begin
      model_acc[k]  = '0;
      sent_count[k] = 0;
      rcv_count[k]  = 0;
    end
    load_stimulus();

    // reset over three rising edges and one quiet cycle after
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      if (i == 2) begin
        #1;
        rst = 1'b0;
      end
      @(negedge clk);
      check_outputs_low();
    end
    @(posedge clk);
    #1;
    reset_done = 1'b1;

    cycles = 0;
    while (!all_done()) begin
      @(negedge clk);
      cycles++;
      assert (cycles < RUN_LIMIT)
        else stop_on_error("packets were still outstanding at the global timeout");
    end

    // no late or duplicated results
    repeat (16) @(negedge clk);
    check_outputs_low();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
src/xbar_pkg.sv
src/pkt_pkg.sv
src/carry_chain_adder.sv
src/dst_fifo.sv
src/src_port.sv
src/xbar_switch.sv
src/dst_port.sv
src/xbar_top.sv
verification/xbar_tb.sv
